//--- source/dip_pkg.sv
// OSD status bit positions, core mode bits and the decoded settings struct
package dip_pkg;

    // OSD status word from the frame
    localparam int STATUS_W = 32;

    // Status bit positions
    localparam int ST_ROT_CONTROL = 2;
    localparam int ST_FLIP        = 3;
    localparam int ST_TEST        = 4;
    localparam int ST_OSD_PAUSE   = 5;
    // Two bits, ST_FXLEVEL and the one above it
    localparam int ST_FXLEVEL     = 6;
    localparam int FXLEVEL_W      = 2;
    // These two disable sound chips when set
    localparam int ST_NO_FM       = 8;
    localparam int ST_NO_PSG      = 9;

    // Core mode bits
    localparam int CORE_MOD_W  = 7;
    localparam int CM_VERTICAL = 0;

    // Settings after decode, all active high
    typedef struct packed {
        logic                 rot_control;
        logic                 vertical;
        logic                 flip;
        logic                 test;
        logic                 osd_pause;
        logic [FXLEVEL_W-1:0] fxlevel;
        logic                 enable_fm;
        logic                 enable_psg;
    } settings_t;

endpackage

//--- source/player_pkg.sv
// Board joystick word, player control struct and direction bit positions
package player_pkg;

    // Raw joystick word as the board delivers it
    localparam int BOARD_JOY_W = 16;

    // Buttons carried by the board word
    localparam int MAX_BUTTONS = 6;

    // Game joystick: direction nibble, buttons above it
    localparam int GAME_JOY_W = 10;

    // Positions inside the direction nibble, same order as the board word
    localparam int DIR_RIGHT = 0;
    localparam int DIR_LEFT  = 1;
    localparam int DIR_DOWN  = 2;
    localparam int DIR_UP    = 3;

    // Board word, active high, LSB first: right left down up buttons start coin pause
    typedef struct packed {
        logic [BOARD_JOY_W-14:0] spare;
        logic                    pause;
        logic                    coin;
        logic                    start;
        logic [MAX_BUTTONS-1:0]  buttons;
        logic                    up;
        logic                    down;
        logic                    left;
        logic                    right;
    } board_joy_t;

    // One player after merging, active high
    typedef struct packed {
        logic [3:0]             dir;
        logic [MAX_BUTTONS-1:0] buttons;
        logic                   coin;
        logic                   start;
    } player_t;

endpackage

//--- source/joy_merge.sv
// Joystick merger: board word registers, unused button mask and pause toggle
`timescale 1ns/1ns

module joy_merge #(
    parameter int BUTTONS = 2
) (
    input  logic                   clk,
    input  logic                   rst,
    input  player_pkg::board_joy_t joy1_in,
    input  player_pkg::board_joy_t joy2_in,
    output player_pkg::player_t    player1,
    output player_pkg::player_t    player2,
    output logic                   key_pause_q
);
    import player_pkg::*;

    // Buttons the game does not use are held at zero
    localparam logic [MAX_BUTTONS-1:0] BTN_MASK = MAX_BUTTONS'((1 << BUTTONS) - 1);

    logic pause_any;
    logic pause_prev;
    logic pause_rise;

    // Board word to player fields
    function automatic player_t to_player(input board_joy_t j);
        player_t p;
        p.dir[DIR_RIGHT] = j.right;
        p.dir[DIR_LEFT]  = j.left;
        p.dir[DIR_DOWN]  = j.down;
        p.dir[DIR_UP]    = j.up;
        p.buttons        = j.buttons & BTN_MASK;
        p.coin           = j.coin;
        p.start          = j.start;
        return p;
    endfunction

    // Either player may pause the game
    assign pause_any  = joy1_in.pause | joy2_in.pause;
    assign pause_rise = pause_any & ~pause_prev;

    always_ff @(posedge clk) begin
        if (rst) begin
            player1 <= '0;
            player2 <= '0;
        end else begin
            player1 <= to_player(joy1_in);
            player2 <= to_player(joy2_in);
        end
    end

    // Pause key acts as a toggle, one flip per press
    always_ff @(posedge clk) begin
        if (rst) begin
            pause_prev  <= 1'b0;
            key_pause_q <= 1'b0;
        end else begin
            pause_prev <= pause_any;
            if (pause_rise) begin
                key_pause_q <= ~key_pause_q;
            end
        end
    end

endmodule

//--- source/status_decode.sv
// Status decoder: settings register from OSD status and core mode, DIP outputs
`timescale 1ns/1ns

module status_decode (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [dip_pkg::STATUS_W-1:0]   status,
    input  logic [dip_pkg::CORE_MOD_W-1:0] core_mod,
    output dip_pkg::settings_t             settings,
    output logic                           dip_flip,
    output logic                           dip_test,
    output logic [dip_pkg::FXLEVEL_W-1:0]  dip_fxlevel,
    output logic                           enable_fm,
    output logic                           enable_psg
);
    import dip_pkg::*;

    settings_t settings_d;

    always_comb begin
        settings_d.rot_control = status[ST_ROT_CONTROL];
        // Vertical games are flagged by the core, not the OSD
        settings_d.vertical    = core_mod[CM_VERTICAL];
        settings_d.flip        = status[ST_FLIP];
        settings_d.test        = status[ST_TEST];
        settings_d.osd_pause   = status[ST_OSD_PAUSE];
        settings_d.fxlevel     = status[ST_FXLEVEL +: FXLEVEL_W];
        // OSD bits say "disable", outputs say "enable"
        settings_d.enable_fm   = ~status[ST_NO_FM];
        settings_d.enable_psg  = ~status[ST_NO_PSG];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            settings <= '0;
        end else begin
            settings <= settings_d;
        end
    end

    // DIP outputs straight from the settings register
    assign dip_flip    = settings.flip;
    assign dip_test    = settings.test;
    assign dip_fxlevel = settings.fxlevel;
    assign enable_fm   = settings.enable_fm;
    assign enable_psg  = settings.enable_psg;

endmodule

//--- source/control_map.sv
// Control mapper: direction rotation, pause masking, output polarity and registers
`timescale 1ns/1ns

module control_map #(
    parameter bit ACTIVE_LOW = 1'b1
) (
    input  logic                            clk,
    input  logic                            rst,
    input  player_pkg::player_t             player1,
    input  player_pkg::player_t             player2,
    input  logic                            key_pause_q,
    input  dip_pkg::settings_t              settings,
    output logic [player_pkg::GAME_JOY_W-1:0] game_joystick1,
    output logic [player_pkg::GAME_JOY_W-1:0] game_joystick2,
    output logic [1:0]                      game_coin,
    output logic [1:0]                      game_start,
    output logic                            dip_pause
);
    import player_pkg::*;

    // XOR masks for the output polarity
    localparam logic [GAME_JOY_W-1:0] JOY_POL  = {GAME_JOY_W{ACTIVE_LOW}};
    localparam logic [1:0]            PAIR_POL = {2{ACTIVE_LOW}};

    logic                  rot_en;
    logic                  game_pause;
    logic [GAME_JOY_W-1:0] joy1_d;
    logic [GAME_JOY_W-1:0] joy2_d;
    logic [1:0]            coin_d;
    logic [1:0]            start_d;

    // Quarter turn of the stick, clockwise unless the screen is flipped
    function automatic logic [3:0] rotate_dir(input logic [3:0] d, input logic ccw);
        logic [3:0] r;
        if (!ccw) begin
            r[DIR_UP]    = d[DIR_LEFT];
            r[DIR_RIGHT] = d[DIR_UP];
            r[DIR_DOWN]  = d[DIR_RIGHT];
            r[DIR_LEFT]  = d[DIR_DOWN];
        end else begin
            r[DIR_UP]    = d[DIR_RIGHT];
            r[DIR_LEFT]  = d[DIR_UP];
            r[DIR_DOWN]  = d[DIR_LEFT];
            r[DIR_RIGHT] = d[DIR_DOWN];
        end
        return r;
    endfunction

    // Game joystick word, buttons above the direction nibble
    function automatic logic [GAME_JOY_W-1:0] map_joy(input player_t p, input logic rot,
                                                     input logic ccw);
        logic [3:0] dir;
        dir = rot ? rotate_dir(p.dir, ccw) : p.dir;
        return {p.buttons, dir};
    endfunction

    always_comb begin
        // Rotation only for vertical games with the OSD option on
        rot_en     = settings.vertical & settings.rot_control;
        game_pause = key_pause_q | settings.osd_pause;
        joy1_d     = map_joy(player1, rot_en, settings.flip);
        joy2_d     = map_joy(player2, rot_en, settings.flip);
        // No credits or starts while paused, sticks still move
        coin_d     = game_pause ? 2'b00 : {player2.coin, player1.coin};
        start_d    = game_pause ? 2'b00 : {player2.start, player1.start};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            game_joystick1 <= JOY_POL;
            game_joystick2 <= JOY_POL;
            game_coin      <= PAIR_POL;
            game_start     <= PAIR_POL;
            dip_pause      <= 1'b1;
        end else begin
            game_joystick1 <= joy1_d ^ JOY_POL;
            game_joystick2 <= joy2_d ^ JOY_POL;
            game_coin      <= coin_d ^ PAIR_POL;
            game_start     <= start_d ^ PAIR_POL;
            // Low while paused
            dip_pause      <= ~game_pause;
        end
    end

endmodule

//--- source/board_inputs.sv
// Board input top level: joystick merger, status decoder and control mapper
`timescale 1ns/1ns

module board_inputs #(
    parameter int BUTTONS    = 2,
    parameter bit ACTIVE_LOW = 1'b1
) (
    input  logic                              clk,
    input  logic                              rst,
    input  player_pkg::board_joy_t            board_joystick1,
    input  player_pkg::board_joy_t            board_joystick2,
    input  logic [dip_pkg::STATUS_W-1:0]      status,
    input  logic [dip_pkg::CORE_MOD_W-1:0]    core_mod,
    output logic [player_pkg::GAME_JOY_W-1:0] game_joystick1,
    output logic [player_pkg::GAME_JOY_W-1:0] game_joystick2,
    output logic [1:0]                        game_coin,
    output logic [1:0]                        game_start,
    output logic                              dip_pause,
    output logic                              dip_flip,
    output logic                              dip_test,
    output logic [dip_pkg::FXLEVEL_W-1:0]     dip_fxlevel,
    output logic                              enable_fm,
    output logic                              enable_psg
);
    import player_pkg::*;
    import dip_pkg::*;

    player_t   player1;
    player_t   player2;
    logic      key_pause_q;
    settings_t settings;

    joy_merge #(
        .BUTTONS    ( BUTTONS         )
    ) u_joy_merge (
        .clk        ( clk             ),
        .rst        ( rst             ),
        .joy1_in    ( board_joystick1 ),
        .joy2_in    ( board_joystick2 ),
        .player1    ( player1         ),
        .player2    ( player2         ),
        .key_pause_q( key_pause_q     )
    );

    status_decode u_status_decode (
        .clk        ( clk             ),
        .rst        ( rst             ),
        .status     ( status          ),
        .core_mod   ( core_mod        ),
        .settings   ( settings        ),
        .dip_flip   ( dip_flip        ),
        .dip_test   ( dip_test        ),
        .dip_fxlevel( dip_fxlevel     ),
        .enable_fm  ( enable_fm       ),
        .enable_psg ( enable_psg      )
    );

    control_map #(
        .ACTIVE_LOW ( ACTIVE_LOW      )
    ) u_control_map (
        .clk           ( clk            ),
        .rst           ( rst            ),
        .player1       ( player1        ),
        .player2       ( player2        ),
        .key_pause_q   ( key_pause_q    ),
        .settings      ( settings       ),
        .game_joystick1( game_joystick1 ),
        .game_joystick2( game_joystick2 ),
        .game_coin     ( game_coin      ),
        .game_start    ( game_start     ),
        .dip_pause     ( dip_pause      )
    );

endmodule

//--- verif/board_inputs_tb.sv
// Board inputs testbench with clock, reset, LCG stimulus, reference model and assertions
`timescale 1ns/1ns

module board_inputs_tb;
    import player_pkg::*;

    localparam int BUTTONS    = 2;
    localparam int WAIT_LIMIT = 20;

    // OSD status bit positions
    localparam int B_ROT   = 2;
    localparam int B_FLIP  = 3;
    localparam int B_TEST  = 4;
    localparam int B_PAUSE = 5;
    localparam int B_FX    = 6;
    localparam int B_NOFM  = 8;
    localparam int B_NOPSG = 9;

    localparam logic [31:0] ROT_MASK   = 32'h1 << B_ROT;
    localparam logic [31:0] FLIP_MASK  = 32'h1 << B_FLIP;
    localparam logic [31:0] PAUSE_MASK = 32'h1 << B_PAUSE;
    localparam logic [5:0]  BTN_KEEP   = 6'((1 << BUTTONS) - 1);

    logic       clk;
    logic       rst;
    board_joy_t board_joystick1;
    board_joy_t board_joystick2;
    logic [31:0] status;
    logic [6:0]  core_mod;
    logic [9:0]  game_joystick1;
    logic [9:0]  game_joystick2;
    logic [1:0]  game_coin;
    logic [1:0]  game_start;
    logic        dip_pause;
    logic        dip_flip;
    logic        dip_test;
    logic [1:0]  dip_fxlevel;
    logic        enable_fm;
    logic        enable_psg;

    logic [31:0] rng;
    int          cycles = 0;

    // Model history where stage 1 is one edge old and stage 2 two edges old
    logic        rst1 = 1'b1;
    board_joy_t  j1_1;
    board_joy_t  j2_1;
    board_joy_t  j1_2;
    board_joy_t  j2_2;
    logic [31:0] st1;
    logic [31:0] st2;
    logic [6:0]  cm1;
    logic [6:0]  cm2;
    logic        pprev;
    logic        tog;
    logic        tog2;

    logic        rot_exp;
    logic        pause_exp;
    logic [9:0]  exp_joy1;
    logic [9:0]  exp_joy2;
    logic [1:0]  exp_coin;
    logic [1:0]  exp_start;
    logic        exp_dip_pause;
    logic [5:0]  exp_dip;

    board_inputs dut0 (
        .clk            ( clk             ),
        .rst            ( rst             ),
        .board_joystick1( board_joystick1 ),
        .board_joystick2( board_joystick2 ),
        .status         ( status          ),
        .core_mod       ( core_mod        ),
        .game_joystick1 ( game_joystick1  ),
        .game_joystick2 ( game_joystick2  ),
        .game_coin      ( game_coin       ),
        .game_start     ( game_start      ),
        .dip_pause      ( dip_pause       ),
        .dip_flip       ( dip_flip        ),
        .dip_test       ( dip_test        ),
        .dip_fxlevel    ( dip_fxlevel     ),
        .enable_fm      ( enable_fm       ),
        .enable_psg     ( enable_psg      )
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Active low game stick word from a board word
    function automatic logic [9:0] expected_joy(input board_joy_t j, input logic rot,
                                                input logic flip);
        logic up;
        logic down;
        logic left;
        logic right;
        up    = j.up;
        down  = j.down;
        left  = j.left;
        right = j.right;
        if (rot && !flip) begin
            // Clockwise quarter turn
            up    = j.left;
            right = j.up;
            down  = j.right;
            left  = j.down;
        end else if (rot) begin
            up    = j.right;
            left  = j.up;
            down  = j.left;
            right = j.down;
        end
        return ~{j.buttons & BTN_KEEP, up, down, left, right};
    endfunction

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] want);
        $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, want);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    // Loop on dip_pause with a cycle limit
    task automatic wait_dip_pause(input logic want);
        int n;
        n = 0;
        while (dip_pause !== want && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (dip_pause !== want) begin
            $display("Timeout: dip_pause did not become %0b within %0d cycles", want, WAIT_LIMIT);
            $display("FAIL: see errors above");
            $fatal(1);
        end
    endtask

    task automatic random_board(output board_joy_t j, input logic pause);
        rng     = lcg_step(rng);
        j       = board_joy_t'(rng[31:16]);
        j.pause = pause;
    endtask

    // Random boards and status with some status bits forced
    task automatic run_random(input int n, input logic [31:0] set_bits,
                              input logic [31:0] clr_bits, input logic p1, input logic p2);
        board_joy_t j1;
        board_joy_t j2;
        for (int i = 0; i < n; i++) begin
            random_board(j1, p1);
            random_board(j2, p2);
            rng = lcg_step(rng);
            @(posedge clk);
            board_joystick1 <= j1;
            board_joystick2 <= j2;
            status          <= (rng & ~clr_bits) | set_bits;
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        rst1   <= rst;
        if (rst) begin
            j1_1  <= '0;
            j2_1  <= '0;
            st1   <= '0;
            cm1   <= '0;
            pprev <= 1'b0;
            tog   <= 1'b0;
        end else begin
            j1_1  <= board_joystick1;
            j2_1  <= board_joystick2;
            st1   <= status;
            cm1   <= core_mod;
            pprev <= board_joystick1.pause | board_joystick2.pause;
            if ((board_joystick1.pause | board_joystick2.pause) && !pprev) begin
                tog <= ~tog;
            end
        end
        j1_2 <= j1_1;
        j2_2 <= j2_1;
        st2  <= st1;
        cm2  <= cm1;
        tog2 <= tog;
    end

    always_comb begin
        rot_exp   = cm2[0] & st2[B_ROT];
        pause_exp = tog2 | st2[B_PAUSE];
        if (rst1) begin
            exp_joy1      = '1;
            exp_joy2      = '1;
            exp_coin      = 2'b11;
            exp_start     = 2'b11;
            exp_dip_pause = 1'b1;
            exp_dip       = '0;
        end else begin
            exp_joy1      = expected_joy(j1_2, rot_exp, st2[B_FLIP]);
            exp_joy2      = expected_joy(j2_2, rot_exp, st2[B_FLIP]);
            exp_coin      = pause_exp ? 2'b11 : ~{j2_2.coin, j1_2.coin};
            exp_start     = pause_exp ? 2'b11 : ~{j2_2.start, j1_2.start};
            exp_dip_pause = ~pause_exp;
            exp_dip       = {st1[B_FLIP], st1[B_TEST], st1[B_FX +: 2],
                             ~st1[B_NOFM], ~st1[B_NOPSG]};
        end
    end

    reset_state: assert property (@(posedge clk) (cycles > 1 && rst1) |->
        (game_joystick1 == 10'h3ff && game_joystick2 == 10'h3ff && game_coin == 2'b11 &&
         game_start == 2'b11 && dip_pause == 1'b1))
        else report_mismatch("reset outputs", $sampled({game_joystick1, game_joystick2,
                             game_coin, game_start, dip_pause}), 32'h1ff_ffff);
    joy1_check: assert property (@(posedge clk) (cycles > 1) |-> game_joystick1 == exp_joy1)
        else report_mismatch("game_joystick1", $sampled(game_joystick1), $sampled(exp_joy1));
    joy2_check: assert property (@(posedge clk) (cycles > 1) |-> game_joystick2 == exp_joy2)
        else report_mismatch("game_joystick2", $sampled(game_joystick2), $sampled(exp_joy2));
    coin_check: assert property (@(posedge clk) (cycles > 1) |-> game_coin == exp_coin)
        else report_mismatch("game_coin", $sampled(game_coin), $sampled(exp_coin));
    start_check: assert property (@(posedge clk) (cycles > 1) |-> game_start == exp_start)
        else report_mismatch("game_start", $sampled(game_start), $sampled(exp_start));
    pause_check: assert property (@(posedge clk) (cycles > 1) |-> dip_pause == exp_dip_pause)
        else report_mismatch("dip_pause", $sampled(dip_pause), $sampled(exp_dip_pause));
    dip_check: assert property (@(posedge clk) (cycles > 1) |->
        {dip_flip, dip_test, dip_fxlevel, enable_fm, enable_psg} == exp_dip)
        else report_mismatch("dip outputs", $sampled({dip_flip, dip_test, dip_fxlevel,
                             enable_fm, enable_psg}), $sampled(exp_dip));

    initial begin
        rng             = 32'h96dd7f5c;
        rst             = 1'b1;
        board_joystick1 = '0;
        board_joystick2 = '0;
        status          = '0;
        core_mod        = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        // Pass-through and then the rotation option on a horizontal game
        run_random(60, 32'h0, ROT_MASK | PAUSE_MASK, 1'b0, 1'b0);
        run_random(20, ROT_MASK, PAUSE_MASK, 1'b0, 1'b0);
        // Vertical game turned clockwise and then flipped
        core_mod <= 7'h01;
        run_random(40, ROT_MASK, FLIP_MASK | PAUSE_MASK, 1'b0, 1'b0);
        run_random(40, ROT_MASK | FLIP_MASK, PAUSE_MASK, 1'b0, 1'b0);
        // Player 1 key pauses and player 2 key resumes
        run_random(1, 32'h0, PAUSE_MASK, 1'b1, 1'b0);
        wait_dip_pause(1'b0);
        run_random(20, 32'h0, PAUSE_MASK, 1'b1, 1'b0);
        run_random(5, 32'h0, PAUSE_MASK, 1'b0, 1'b0);
        run_random(1, 32'h0, PAUSE_MASK, 1'b0, 1'b1);
        wait_dip_pause(1'b1);
        run_random(5, 32'h0, PAUSE_MASK, 1'b0, 1'b0);
        // OSD pause
        run_random(1, PAUSE_MASK, 32'h0, 1'b0, 1'b0);
        wait_dip_pause(1'b0);
        run_random(20, PAUSE_MASK, 32'h0, 1'b0, 1'b0);
        run_random(1, 32'h0, PAUSE_MASK, 1'b0, 1'b0);
        wait_dip_pause(1'b1);
        // Fully random status words for the DIP decode
        core_mod <= rng[6:0];
        run_random(100, 32'h0, 32'h0, 1'b0, 1'b0);
        // Drain the pipeline and let the last checks run
        repeat (3) @(posedge clk);
        @(negedge clk);
        $display("PASS: all tests");
        $finish;
    end

endmodule

//--- verilog.f
source/dip_pkg.sv
source/player_pkg.sv
source/joy_merge.sv
source/status_decode.sv
source/control_map.sv
source/board_inputs.sv
verif/board_inputs_tb.sv

//--- run.sh
#!/bin/sh
# Verilator build and run of the board input testbench
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert -f verilog.f --top-module board_inputs_tb \
    -Mdir obj_dir -o board_inputs_sim > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/board_inputs_sim > sim.log 2>&1 ; cat sim.log
grep -q "FAIL: see errors above" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "PASS: all tests" sim.log || { echo "Simulation ended early"; exit 1; }
echo "Simulation passed"
